/* soc_periph.f */
+incdir+tests
hw/soc_periph_pkg.sv
hw/apb_slot_decoder.sv
hw/riscv_mtimer.sv
hw/uart_regs.sv
hw/uart_tx_serializer.sv
hw/periph_top.sv
tests/tb_periph_top.sv

/* Makefile */
# Verilator build and run for the peripheral subsystem testbench

SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_periph_top
FILELIST = soc_periph.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard hw/*.sv) $(wildcard tests/*)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/periph_patterns.txt */
// columns: op, address, data, pslverr; ops 01 write, 02 read, 03 UART byte in data,
// 04 halt level, 05 wait irq level, 06 idle cycles, 07 read above data, 00 end
// reset values
05 0000 00000000 0
02 0000 00000000 0
02 0008 00000000 0
02 000C 00000000 0
02 0010 FFFFFFFF 0
02 0014 FFFFFFFF 0
02 4008 000000EA 0
02 4004 00000000 0
// readback of mtimecmp halves and the divider
01 0010 12345678 0
01 0014 9ABCDEF0 0
02 0010 12345678 0
02 0014 9ABCDEF0 0
01 4008 00000014 0
02 4008 00000014 0
// unmapped slots 2 and 3
01 8010 00000001 1
02 8010 00000000 1
01 C008 00000005 1
02 C008 00000000 1
02 0010 12345678 0
02 4008 00000014 0
// framing at divider 20
01 4000 00000055 0
01 4000 000000A3 0
01 4000 0000000F 0
03 0000 00000055 0
03 0000 000000A3 0
03 0000 0000000F 0
// queue full at divider 200
01 4008 000000C8 0
01 4000 00000011 0
01 4000 00000012 0
01 4000 00000013 0
01 4000 00000014 0
01 4000 00000015 0
01 4000 00000016 1
02 4004 00000003 0
03 0000 00000011 0
03 0000 00000012 0
03 0000 00000013 0
03 0000 00000014 0
03 0000 00000015 0
06 0000 000000C8 0
02 4004 00000000 0
// timer interrupt
01 0000 00000001 0
01 0008 00000000 0
01 000C 00000000 0
01 0014 00000000 0
01 0010 00000003 0
05 0000 00000001 0
01 0014 FFFFFFFF 0
05 0000 00000000 0
// debug halt
04 0000 00000001 0
01 0008 00000100 0
02 0008 00000100 0
06 0000 000000C8 0
02 0008 00000100 0
02 000C 00000000 0
04 0000 00000000 0
06 0000 000000C8 0
07 0008 00000100 0
00 0000 00000000 0

/* tests/tb_checks.svh */
// APB access task and typed compare tasks of the peripheral testbench
// included inside the testbench module where it uses the bus signals and error counters

// one APB transfer of a setup cycle and access cycles until pready
task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata, output apb_rsp_t rsp);
    int unsigned waited;
    logic        got;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    waited = 0;
    got = 1'b0;
    while (!got && waited < APB_TIMEOUT) begin
        // registers cannot move before the next rising edge
        #5;
        // only the first access cycle counts as the response
        if (waited == 0) begin
            rsp = apb_rsp;
        end
        if (apb_rsp.pready === 1'b1) begin
            got = 1'b1;
        end
        @(negedge clk);
        waited++;
    end
    if (!got) begin
        $display("APB access to %h saw no pready within %0d cycles", addr, APB_TIMEOUT);
        timeout_count++;
    end
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
endtask

task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t expected,
                         input logic with_data, input logic [APB_ADDR_W-1:0] addr);
    if (got.pready !== expected.pready || got.pslverr !== expected.pslverr ||
        (with_data && got.prdata !== expected.prdata)) begin
        $display("[FAIL] %t: access to %h got prdata %h pready %b pslverr %b", $time, addr,
                 got.prdata, got.pready, got.pslverr);
        $display("       expected prdata %h pready %b pslverr %b",
                 expected.prdata, expected.pready, expected.pslverr);
        error_count++;
    end
endtask

// takes the oldest byte decoded by the line monitor
task automatic check_byte(input uart_byte_t expected);
    int unsigned waited;
    int unsigned limit;
    uart_byte_t  got;
    limit = 24 * mon_div + 100;
    waited = 0;
    while (rx_bytes.size() == 0 && waited < limit) begin
        @(negedge clk);
        waited++;
    end
    if (rx_bytes.size() == 0) begin
        $display("no UART byte arrived within %0d cycles, expected %h", limit, expected);
        timeout_count++;
    end else begin
        got = rx_bytes.pop_front();
        if (got !== expected) begin
            $display("[FAIL] %t: UART byte %h, expected %h", $time, got, expected);
            error_count++;
        end
    end
endtask

task automatic check_irq(input logic got, input logic expected);
    if (got !== expected) begin
        $display("[FAIL] %t: timer irq is %b, expected %b", $time, got, expected);
        error_count++;
    end
endtask

/* tests/tb_periph_top.sv */
// testbench for the peripheral subsystem that replays tests/periph_patterns.txt
// and decodes the UART line; build and run with the Makefile
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top import soc_periph_pkg::*; ();

    localparam int unsigned MAX_OPS = 128;
    localparam int unsigned APB_TIMEOUT = 16;
    localparam int unsigned IRQ_TIMEOUT = 500;

    localparam logic [7:0] OP_END = 8'h00;
    localparam logic [7:0] OP_WRITE = 8'h01;
    localparam logic [7:0] OP_READ = 8'h02;
    localparam logic [7:0] OP_BYTE = 8'h03;
    localparam logic [7:0] OP_HALT = 8'h04;
    localparam logic [7:0] OP_IRQ = 8'h05;
    localparam logic [7:0] OP_IDLE = 8'h06;
    localparam logic [7:0] OP_READ_ABOVE = 8'h07;

    // divider register in the uart slot
    localparam logic [APB_ADDR_W-1:0] UART_DIV_ADDR = 16'h4008;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        dbg_halt;
    logic        timer_irq;
    logic        uart_tx;

    // each operation takes four words of op, address, data and pslverr
    logic [31:0] patterns [MAX_OPS * 4];
    int unsigned error_count;
    int unsigned timeout_count;

    // line monitor
    uart_byte_t  rx_bytes [$];
    int unsigned mon_div;
    logic        mon_active;
    int unsigned mon_cnt;
    int unsigned mon_bit;
    uart_byte_t  mon_shift;

    periph_top i_periph_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp),
        .i_dbg_halt  (dbg_halt),
        .o_timer_irq (timer_irq),
        .o_uart_tx   (uart_tx)
    );

    `include "tb_checks.svh"

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // UART line monitor sampling each bit at mid-period
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst_n) begin
            mon_active = 1'b0;
            mon_cnt = 0;
            mon_bit = 0;
            mon_shift = '0;
        end else if (!mon_active) begin
            if (uart_tx == 1'b0) begin
                mon_active = 1'b1;
                mon_cnt = mon_div / 2;
                mon_bit = 0;
            end
        end else if (mon_cnt > 1) begin
            mon_cnt--;
        end else begin
            mon_cnt = mon_div;
            if (mon_bit == 0) begin
                if (uart_tx != 1'b0) begin
                    $display("UART start bit did not last to mid-period at %t", $time);
                    error_count++;
                    mon_active = 1'b0;
                end
            end else if (mon_bit <= 8) begin
                // lsb first
                mon_shift = {uart_tx, mon_shift[7:1]};
            end else begin
                if (uart_tx != 1'b1) begin
                    $display("[FAIL] %t: UART stop bit is low", $time);
                    error_count++;
                end
                rx_bytes.push_back(mon_shift);
                mon_active = 1'b0;
            end
            mon_bit++;
        end
    end

    // ----------------------------------------------------------------------
    // pattern driver
    // ----------------------------------------------------------------------

    initial begin
        int unsigned           idx;
        int unsigned           waited;
        logic                  done;
        logic [7:0]            op;
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] data;
        logic                  flag;
        apb_rsp_t              rsp;
        apb_rsp_t              expected;

        $timeformat(-9, 0, " ns", 0);
        error_count = 0;
        timeout_count = 0;
        rst_n = 1'b0;
        dbg_halt = 1'b0;
        apb_req = '0;
        mon_div = 32'(UART_DIV_RESET);
        for (idx = 0; idx < MAX_OPS * 4; idx++) begin
            patterns[idx] = '0;
        end
        $readmemh("tests/periph_patterns.txt", patterns);

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (uart_tx !== 1'b1) begin
            $display("[FAIL] %t: UART line is not idle high after reset", $time);
            error_count++;
        end

        done = 1'b0;
        idx = 0;
        while (!done && idx < MAX_OPS) begin
            op = patterns[idx * 4][7:0];
            addr = patterns[idx * 4 + 1][APB_ADDR_W-1:0];
            data = patterns[idx * 4 + 2];
            flag = patterns[idx * 4 + 3][0];
            expected.prdata = data;
            expected.pready = 1'b1;
            expected.pslverr = flag;
            case (op)
                OP_WRITE: begin
                    apb_access(1'b1, addr, data, rsp);
                    check_rsp(rsp, expected, 1'b0, addr);
                    // monitor follows the divider written here
                    if (addr == UART_DIV_ADDR) begin
                        mon_div = 32'(data[UART_DIV_W-1:0]);
                    end
                end
                OP_READ: begin
                    apb_access(1'b0, addr, '0, rsp);
                    check_rsp(rsp, expected, 1'b1, addr);
                end
                OP_READ_ABOVE: begin
                    apb_access(1'b0, addr, '0, rsp);
                    check_rsp(rsp, expected, 1'b0, addr);
                    if (rsp.prdata <= data) begin
                        $display("[FAIL] %t: read of %h gave %h, expected above %h",
                                 $time, addr, rsp.prdata, data);
                        error_count++;
                    end
                end
                OP_BYTE: check_byte(data[7:0]);
                OP_HALT: dbg_halt = data[0];
                OP_IRQ: begin
                    waited = 0;
                    while (timer_irq !== data[0] && waited < IRQ_TIMEOUT) begin
                        @(negedge clk);
                        waited++;
                    end
                    check_irq(timer_irq, data[0]);
                end
                OP_IDLE: repeat (data) @(negedge clk);
                OP_END: done = 1'b1;
                default: begin
                    $display("pattern %0d has an unknown operation code %h", idx, op);
                    error_count++;
                end
            endcase
            idx++;
        end

        if (rx_bytes.size() != 0) begin
            $display("UART sent %0d bytes that no pattern expected", rx_bytes.size());
            error_count++;
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/periph_top.sv */
// peripheral subsystem top: APB slot decoder, machine timer and
// transmit-only UART behind one APB port
`timescale 1ns/1ps
`default_nettype none

module periph_top import soc_periph_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    input  wire      i_dbg_halt,
    output logic     o_timer_irq,
    output logic     o_uart_tx
);

    apb_req_t              timer_req;
    apb_req_t              uart_req;
    apb_rsp_t              timer_rsp;
    apb_rsp_t              uart_rsp;
    uart_byte_t            tx_byte;
    logic                  tx_valid;
    logic                  tx_ready;
    logic [UART_DIV_W-1:0] uart_div;

    // ----------------------------------------------------------------------
    // bus side
    // ----------------------------------------------------------------------

    apb_slot_decoder i_apb_slot_decoder (
        .i_req       (i_apb),
        .o_timer_req (timer_req),
        .o_uart_req  (uart_req),
        .i_timer_rsp (timer_rsp),
        .i_uart_rsp  (uart_rsp),
        .o_rsp       (o_apb)
    );

    // ----------------------------------------------------------------------
    // peripherals
    // ----------------------------------------------------------------------

    riscv_mtimer i_riscv_mtimer (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (timer_req),
        .o_rsp      (timer_rsp),
        .i_dbg_halt (i_dbg_halt),
        .o_irq      (o_timer_irq)
    );

    uart_regs i_uart_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (uart_req),
        .o_rsp   (uart_rsp),
        .o_byte  (tx_byte),
        .o_valid (tx_valid),
        .i_ready (tx_ready),
        .o_div   (uart_div)
    );

    uart_tx_serializer i_uart_tx_serializer (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_byte  (tx_byte),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .i_div   (uart_div),
        .o_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

/* hw/uart_tx_serializer.sv */
// shifts one byte at a time onto the line as an 8N1 frame,
// each bit lasting i_div clock cycles
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer import soc_periph_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  uart_byte_t            i_byte,
    input  wire                   i_valid,
    output logic                  o_ready,
    input  wire [UART_DIV_W-1:0]  i_div,
    output logic                  o_tx
);

    typedef enum logic {
        S_IDLE,
        S_SHIFT
    } state_t;

    state_t                state;
    logic [UART_DIV_W-1:0] baud_cnt;
    logic [3:0]            bits_left;
    // stop, data lsb first, start; bit 0 is on the line
    logic [9:0]            shreg;
    logic                  load;
    logic                  bit_done;

    assign o_ready = (state == S_IDLE);
    assign load = o_ready & i_valid;
    assign bit_done = (baud_cnt == '0);
    assign o_tx = shreg[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            baud_cnt <= '0;
            bits_left <= '0;
            shreg <= '1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (load) begin
                        // start bit goes out right after the handshake edge
                        shreg <= {1'b1, i_byte, 1'b0};
                        baud_cnt <= i_div - 1'b1;
                        bits_left <= 4'd9;
                        state <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (bit_done) begin
                        // ones shift in behind the stop bit, line stays idle high
                        shreg <= {1'b1, shreg[9:1]};
                        baud_cnt <= i_div - 1'b1;
                        if (bits_left == '0) begin
                            state <= S_IDLE;
                        end else begin
                            bits_left <= bits_left - 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/uart_regs.sv */
// UART register block: transmit byte queue, status and bit divider,
// feeding the serializer over a valid/ready link
`timescale 1ns/1ps
`default_nettype none

module uart_regs import soc_periph_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  apb_req_t               i_req,
    output apb_rsp_t               o_rsp,
    output uart_byte_t             o_byte,
    output logic                   o_valid,
    input  wire                    i_ready,
    output logic [UART_DIV_W-1:0]  o_div
);

    localparam int unsigned PTR_W = $clog2(UART_FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(UART_FIFO_DEPTH + 1);

    uart_byte_t           fifo_mem [UART_FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 full;
    logic                 busy;
    logic                 data_wr;
    logic                 push;
    logic                 pop;
    logic [REG_OFF_W-1:0] offset;
    logic                 wr_en;

    assign offset = i_req.paddr[REG_OFF_W-1:0];
    assign wr_en = i_req.psel & i_req.penable & i_req.pwrite;
    assign data_wr = wr_en & (offset == UART_DATA);

    assign full = (count == CNT_W'(UART_FIFO_DEPTH));
    // a write into a full queue is dropped
    assign push = data_wr & ~full;
    assign pop = o_valid & i_ready;

    assign o_valid = (count != '0);
    assign o_byte = fifo_mem[rd_ptr];
    assign busy = o_valid | ~i_ready;

    // ----------------------------------------------------------------------
    // transmit queue
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= i_req.pwdata[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(UART_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(UART_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // divider register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_div <= UART_DIV_RESET;
        end else if (wr_en && offset == UART_DIV) begin
            o_div <= i_req.pwdata[UART_DIV_W-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------

    always_comb begin
        case (offset)
            UART_STATUS: o_rsp.prdata = {30'd0, full, busy};
            UART_DIV:    o_rsp.prdata = {{(APB_DATA_W - UART_DIV_W){1'b0}}, o_div};
            default:     o_rsp.prdata = '0;
        endcase
        o_rsp.pready = 1'b1;
        o_rsp.pslverr = data_wr & full;
    end

endmodule

`default_nettype wire

/* hw/riscv_mtimer.sv */
// RISC-V machine timer on APB: 64-bit mtime on a microsecond timebase,
// 64-bit mtimecmp, freeze on debug halt and a registered compare interrupt
`timescale 1ns/1ps
`default_nettype none

module riscv_mtimer import soc_periph_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  apb_req_t i_req,
    output apb_rsp_t o_rsp,
    input  wire      i_dbg_halt,
    output logic     o_irq
);

    localparam int unsigned TICK_W = $clog2(CLK_MHZ);

    logic [TICK_W-1:0]    tick_ctr;
    logic                 tick;
    logic                 enable;
    logic [63:0]          mtime;
    logic [63:0]          mtimecmp;
    logic [REG_OFF_W-1:0] offset;
    logic                 wr_en;
    logic                 mtime_wr;

    assign offset = i_req.paddr[REG_OFF_W-1:0];
    assign wr_en = i_req.psel & i_req.penable & i_req.pwrite;
    assign mtime_wr = wr_en & ((offset == TMR_MTIME_LO) | (offset == TMR_MTIME_HI));

    // ----------------------------------------------------------------------
    // microsecond timebase
    // ----------------------------------------------------------------------

    // free running, one tick every CLK_MHZ cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_ctr <= TICK_W'(CLK_MHZ - 1);
        end else if (tick) begin
            tick_ctr <= TICK_W'(CLK_MHZ - 1);
        end else begin
            tick_ctr <= tick_ctr - 1'b1;
        end
    end

    assign tick = (tick_ctr == '0);

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
            mtime <= '0;
            mtimecmp <= '1;
        end else begin
            // a bus write to mtime wins over the tick in the same cycle
            if (mtime_wr) begin
                if (offset == TMR_MTIME_LO) begin
                    mtime <= {mtime[63:32], i_req.pwdata};
                end else begin
                    mtime <= {i_req.pwdata, mtime[31:0]};
                end
            end else if (tick && enable && !i_dbg_halt) begin
                mtime <= mtime + 64'd1;
            end

            if (wr_en) begin
                case (offset)
                    TMR_CTRL:        enable <= i_req.pwdata[0];
                    TMR_MTIMECMP_LO: mtimecmp <= {mtimecmp[63:32], i_req.pwdata};
                    TMR_MTIMECMP_HI: mtimecmp <= {i_req.pwdata, mtimecmp[31:0]};
                    default:         ;
                endcase
            end
        end
    end

    // compare result, one cycle behind the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_irq <= 1'b0;
        end else begin
            o_irq <= (mtime >= mtimecmp);
        end
    end

    // ----------------------------------------------------------------------
    // read side, no wait states and no errors
    // ----------------------------------------------------------------------

    always_comb begin
        case (offset)
            TMR_CTRL:        o_rsp.prdata = {31'd0, enable};
            TMR_MTIME_LO:    o_rsp.prdata = mtime[31:0];
            TMR_MTIME_HI:    o_rsp.prdata = mtime[63:32];
            TMR_MTIMECMP_LO: o_rsp.prdata = mtimecmp[31:0];
            TMR_MTIMECMP_HI: o_rsp.prdata = mtimecmp[63:32];
            default:         o_rsp.prdata = '0;
        endcase
        o_rsp.pready = 1'b1;
        o_rsp.pslverr = 1'b0;
    end

endmodule

`default_nettype wire

/* hw/apb_slot_decoder.sv */
// routes an APB request to the timer or UART slot by the top address bits
// and returns the selected response; unmapped slots answer with an error
`timescale 1ns/1ps
`default_nettype none

module apb_slot_decoder import soc_periph_pkg::*; (
    input  apb_req_t i_req,
    output apb_req_t o_timer_req,
    output apb_req_t o_uart_req,
    input  apb_rsp_t i_timer_rsp,
    input  apb_rsp_t i_uart_rsp,
    output apb_rsp_t o_rsp
);

    logic [SLOT_W-1:0] slot;
    logic              sel_timer;
    logic              sel_uart;

    assign slot = i_req.paddr[APB_ADDR_W-1 -: SLOT_W];
    assign sel_timer = (slot == SLOT_TIMER);
    assign sel_uart = (slot == SLOT_UART);

    // ----------------------------------------------------------------------
    // request fan-out
    // ----------------------------------------------------------------------

    // everything but psel goes to both peripherals
    always_comb begin
        o_timer_req = i_req;
        o_timer_req.psel = i_req.psel & sel_timer;

        o_uart_req = i_req;
        o_uart_req.psel = i_req.psel & sel_uart;
    end

    // ----------------------------------------------------------------------
    // response merge
    // ----------------------------------------------------------------------

    always_comb begin
        if (sel_timer) begin
            o_rsp = i_timer_rsp;
        end else if (sel_uart) begin
            o_rsp = i_uart_rsp;
        end else begin
            // unmapped slot, zero data and an error with no wait state
            o_rsp.prdata = '0;
            o_rsp.pready = 1'b1;
            o_rsp.pslverr = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/soc_periph_pkg.sv */
// shared constants, register map and bus types of the peripheral subsystem
// imported by every module under hw/
`default_nettype none

package soc_periph_pkg;

    // ----------------------------------------------------------------------
    // clocking and bus geometry
    // ----------------------------------------------------------------------

    // clock cycles per microsecond tick
    localparam int unsigned CLK_MHZ = 27;

    localparam int unsigned APB_ADDR_W = 16;
    localparam int unsigned APB_DATA_W = 32;

    // slot chosen by the top address bits
    localparam int unsigned N_SLOTS = 4;
    localparam int unsigned SLOT_W = $clog2(N_SLOTS);
    localparam logic [SLOT_W-1:0] SLOT_TIMER = SLOT_W'(0);
    localparam logic [SLOT_W-1:0] SLOT_UART = SLOT_W'(1);

    // peripherals decode only this many low address bits
    localparam int unsigned REG_OFF_W = 8;

    // ----------------------------------------------------------------------
    // timer register map
    // ----------------------------------------------------------------------

    // bit 0 enables counting
    localparam logic [REG_OFF_W-1:0] TMR_CTRL = 8'h00;
    localparam logic [REG_OFF_W-1:0] TMR_MTIME_LO = 8'h08;
    localparam logic [REG_OFF_W-1:0] TMR_MTIME_HI = 8'h0C;
    localparam logic [REG_OFF_W-1:0] TMR_MTIMECMP_LO = 8'h10;
    localparam logic [REG_OFF_W-1:0] TMR_MTIMECMP_HI = 8'h14;

    // ----------------------------------------------------------------------
    // uart register map
    // ----------------------------------------------------------------------

    localparam logic [REG_OFF_W-1:0] UART_DATA = 8'h00;
    // bit 0 busy, bit 1 queue full
    localparam logic [REG_OFF_W-1:0] UART_STATUS = 8'h04;
    localparam logic [REG_OFF_W-1:0] UART_DIV = 8'h08;

    localparam int unsigned UART_FIFO_DEPTH = 4;
    localparam int unsigned UART_DIV_W = 16;
    localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd234;

    // ----------------------------------------------------------------------
    // bus types
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire
